// File: design/lsu_pkg.sv
// shared definitions for the memory-access stage
// data and address width, load and store width codes,
// data memory geometry, AXI id width and the memory word union

package lsu_pkg;

    localparam int XLEN        = 32;
    localparam int MEM_WORDS   = 256;
    localparam int MEM_INDEX_W = 8;   // address bits 9:2
    localparam int AXI_ID_W    = 4;

    // load width codes in funct3
    localparam logic [2:0] FUNCT3_LB  = 3'b000;
    localparam logic [2:0] FUNCT3_LH  = 3'b001;
    localparam logic [2:0] FUNCT3_LW  = 3'b010;
    localparam logic [2:0] FUNCT3_LBU = 3'b100;
    localparam logic [2:0] FUNCT3_LHU = 3'b101;

    // store width codes in funct3
    localparam logic [2:0] FUNCT3_SB  = 3'b000;
    localparam logic [2:0] FUNCT3_SH  = 3'b001;
    localparam logic [2:0] FUNCT3_SW  = 3'b010;

    // one memory word seen as word, halves or bytes
    typedef union packed {
        logic [XLEN-1:0]       word;
        logic [1:0][15:0]      half;  // half[1] is the upper half
        logic [3:0][7:0]       lane;  // lane[0] at byte offset 0
    } mem_word_u;

endpackage

// File: design/axi_if.sv
// AXI4 bundle for single-beat transfers
// master and slave modports without length or burst fields

`timescale 1ns/1ps

interface axi_if;
    import lsu_pkg::*;

    logic                  awvalid;
    logic                  awready;
    logic [AXI_ID_W-1:0]   awid;
    logic [XLEN-1:0]       awaddr;
    logic [2:0]            awsize;

    logic                  wvalid;
    logic                  wready;
    logic [XLEN-1:0]       wdata;
    logic [XLEN/8-1:0]     wstrb;
    logic                  wlast;

    logic                  bvalid;
    logic                  bready;
    logic [AXI_ID_W-1:0]   bid;
    logic [1:0]            bresp;

    logic                  arvalid;
    logic                  arready;
    logic [AXI_ID_W-1:0]   arid;
    logic [XLEN-1:0]       araddr;
    logic [2:0]            arsize;

    logic                  rvalid;
    logic                  rready;
    logic [AXI_ID_W-1:0]   rid;
    logic [XLEN-1:0]       rdata;
    logic [1:0]            rresp;
    logic                  rlast;

    modport master (
        output awvalid, awid, awaddr, awsize, wvalid, wdata, wstrb, wlast, bready,
        output arvalid, arid, araddr, arsize, rready,
        input  awready, wready, bvalid, bid, bresp, arready, rvalid, rid, rdata, rresp, rlast
    );

    modport slave (
        input  awvalid, awid, awaddr, awsize, wvalid, wdata, wstrb, wlast, bready,
        input  arvalid, arid, araddr, arsize, rready,
        output awready, wready, bvalid, bid, bresp, arready, rvalid, rid, rdata, rresp, rlast
    );

endinterface

// File: design/load_extract.sv
// load lane selection
// picks byte or halfword lane of a read word, sign or zero extends

`timescale 1ns/1ps

module load_extract (
    input  lsu_pkg::mem_word_u        rdata,
    input  logic [1:0]                byte_offset,
    input  logic [2:0]                funct3,
    output logic [lsu_pkg::XLEN-1:0]  load_value
);
    import lsu_pkg::*;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    assign sel_byte = rdata.lane[byte_offset];
    assign sel_half = rdata.half[byte_offset[1]];   // bit 0 unused for aligned halves

    always_comb begin
        case (funct3)
            FUNCT3_LB: begin
                load_value = {{(XLEN-8){sel_byte[7]}}, sel_byte};
            end
            FUNCT3_LH: begin
                load_value = {{(XLEN-16){sel_half[15]}}, sel_half};
            end
            FUNCT3_LW: begin
                load_value = rdata.word;
            end
            FUNCT3_LBU: begin
                load_value = {{(XLEN-8){1'b0}}, sel_byte};
            end
            FUNCT3_LHU: begin
                load_value = {{(XLEN-16){1'b0}}, sel_half};
            end
            default: begin
                load_value = '0;
            end
        endcase
    end

endmodule

// File: design/lsu.sv
// memory-access stage of the core
// pipeline register, AXI4 request and response control,
// store lane alignment, load capture and result select

`timescale 1ns/1ps

module lsu (
    input  logic                      clock,
    input  logic                      reset,

    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [lsu_pkg::XLEN-1:0]  pc,
    input  logic [lsu_pkg::XLEN-1:0]  inst,
    input  logic [lsu_pkg::XLEN-1:0]  alu_result,
    input  logic [lsu_pkg::XLEN-1:0]  store_data,
    input  logic [2:0]                funct3,
    input  logic                      mem_ren,
    input  logic                      mem_wen,
    input  logic [4:0]                rd,
    input  logic                      reg_wen,

    output logic                      out_valid,
    input  logic                      out_ready,
    output logic [lsu_pkg::XLEN-1:0]  out_pc,
    output logic [lsu_pkg::XLEN-1:0]  out_inst,
    output logic [4:0]                out_rd,
    output logic                      out_reg_wen,
    output logic [lsu_pkg::XLEN-1:0]  out_result,
    output logic                      mem_req,

    axi_if.master                     bus
);
    import lsu_pkg::*;

    logic                 accept;
    logic                 wait_bus;   // memory access in flight
    logic                 r_done;
    logic                 b_done;
    logic                 awvalid_q, wvalid_q, bready_q, arvalid_q, rready_q;

    logic [XLEN-1:0]      pc_q, inst_q, addr_q, load_q;
    logic [4:0]           rd_q;
    logic                 reg_wen_q, load_q_sel;
    logic [2:0]           funct3_q;
    mem_word_u            st_word, wdata_q;
    logic [XLEN/8-1:0]    st_strb, wstrb_q;
    logic [XLEN-1:0]      load_value;

    assign in_ready = !wait_bus && (!out_valid || out_ready);
    assign accept   = in_valid && in_ready;
    assign r_done   = bus.rvalid && rready_q;
    assign b_done   = bus.bvalid && bready_q;
    assign mem_req  = wait_bus;

    // place store data in the addressed lanes
    always_comb begin
        st_word.word = '0;
        st_strb      = '0;
        case (funct3)
            FUNCT3_SB: begin
                st_word.lane[alu_result[1:0]] = store_data[7:0];
                st_strb[alu_result[1:0]]      = 1'b1;
            end
            FUNCT3_SH: begin
                st_word.half[alu_result[1]] = store_data[15:0];
                st_strb = alu_result[1] ? 4'b1100 : 4'b0011;
            end
            FUNCT3_SW: begin
                st_word.word = store_data;
                st_strb      = '1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            pc_q       <= pc;
            inst_q     <= inst;
            addr_q     <= alu_result;
            rd_q       <= rd;
            reg_wen_q  <= reg_wen;
            funct3_q   <= funct3;
            load_q_sel <= mem_ren;
            wdata_q    <= st_word;
            wstrb_q    <= st_strb;
        end
        if (r_done) begin
            load_q <= load_value;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wait_bus  <= 1'b0;
            out_valid <= 1'b0;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
            bready_q  <= 1'b0;
            arvalid_q <= 1'b0;
            rready_q  <= 1'b0;
        end else begin
            if (accept && mem_ren) begin
                arvalid_q <= 1'b1;
                rready_q  <= 1'b1;
            end else if (accept && mem_wen) begin
                awvalid_q <= 1'b1;
                wvalid_q  <= 1'b1;
                bready_q  <= 1'b1;
            end
            if (arvalid_q && bus.arready) arvalid_q <= 1'b0;
            if (awvalid_q && bus.awready) awvalid_q <= 1'b0;
            if (wvalid_q && bus.wready)   wvalid_q  <= 1'b0;
            if (r_done) rready_q <= 1'b0;
            if (b_done) bready_q <= 1'b0;

            if (accept && (mem_ren || mem_wen)) begin
                wait_bus <= 1'b1;
            end else if (r_done || b_done) begin
                wait_bus <= 1'b0;
            end

            if (accept && !mem_ren && !mem_wen) begin
                out_valid <= 1'b1;
            end else if (r_done || b_done) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    load_extract load_extract_inst (
        .rdata       (bus.rdata),
        .byte_offset (addr_q[1:0]),
        .funct3      (funct3_q),
        .load_value  (load_value)
    );

    assign bus.awvalid = awvalid_q;
    assign bus.awid    = '0;
    assign bus.awaddr  = addr_q;
    assign bus.awsize  = {1'b0, funct3_q[1:0]};   // 1, 2 or 4 bytes
    assign bus.wvalid  = wvalid_q;
    assign bus.wdata   = wdata_q.word;
    assign bus.wstrb   = wstrb_q;
    assign bus.wlast   = 1'b1;
    assign bus.bready  = bready_q;
    assign bus.arvalid = arvalid_q;
    assign bus.arid    = '0;
    assign bus.araddr  = addr_q;
    assign bus.arsize  = {1'b0, funct3_q[1:0]};
    assign bus.rready  = rready_q;

    assign out_pc      = pc_q;
    assign out_inst    = inst_q;
    assign out_rd      = rd_q;
    assign out_reg_wen = reg_wen_q;
    assign out_result  = load_q_sel ? load_q : addr_q;

endmodule

// File: design/axi_sram.sv
// AXI4 slave data memory
// byte-strobe writes, single-beat reads with one cycle of read latency,
// OKAY responses with the request id echoed

`timescale 1ns/1ps

module axi_sram (
    input  logic  clock,
    input  logic  reset,
    axi_if.slave  bus
);
    import lsu_pkg::*;

    mem_word_u                 mem [MEM_WORDS];
    mem_word_u                 wdata_u;
    logic [MEM_INDEX_W-1:0]    aw_idx, ar_idx, ar_idx_q;
    logic                      aw_fire, ar_fire;
    logic                      ar_pend;   // address taken and data not yet out
    logic                      bvalid_q, rvalid_q;
    logic [AXI_ID_W-1:0]       bid_q, rid_q;
    logic [XLEN-1:0]           rdata_q;

    assign wdata_u.word = bus.wdata;
    assign aw_idx       = bus.awaddr[MEM_INDEX_W+1:2];
    assign ar_idx       = bus.araddr[MEM_INDEX_W+1:2];

    assign bus.awready = bus.awvalid && bus.wvalid && !bvalid_q;
    assign bus.wready  = bus.awready;
    assign aw_fire     = bus.awready;
    assign bus.arready = !ar_pend && !rvalid_q;
    assign ar_fire     = bus.arvalid && bus.arready;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (aw_fire) begin
            for (int b = 0; b < XLEN/8; b++) begin
                if (bus.wstrb[b]) begin
                    mem[aw_idx].lane[b] <= wdata_u.lane[b];   // strobed merge
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
            ar_pend  <= 1'b0;
        end else begin
            if (aw_fire) begin
                bvalid_q <= 1'b1;
            end else if (bus.bready) begin
                bvalid_q <= 1'b0;
            end

            if (ar_fire) begin
                ar_pend <= 1'b1;
            end else if (ar_pend) begin
                ar_pend  <= 1'b0;
                rvalid_q <= 1'b1;
            end else if (bus.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (aw_fire) bid_q <= bus.awid;
        if (ar_fire) begin
            ar_idx_q <= ar_idx;
            rid_q    <= bus.arid;
        end
        if (ar_pend) rdata_q <= mem[ar_idx_q].word;
    end

    assign bus.bvalid = bvalid_q;
    assign bus.bid    = bid_q;
    assign bus.bresp  = 2'b00;   // OKAY
    assign bus.rvalid = rvalid_q;
    assign bus.rid    = rid_q;
    assign bus.rdata  = rdata_q;
    assign bus.rresp  = 2'b00;
    assign bus.rlast  = 1'b1;

endmodule

// File: design/mem_stage.sv
// top level of the memory-access stage
// memory-access stage and AXI4 data memory joined by one bus

`timescale 1ns/1ps

module mem_stage (
    input  logic                      clock,
    input  logic                      reset,

    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [lsu_pkg::XLEN-1:0]  pc,
    input  logic [lsu_pkg::XLEN-1:0]  inst,
    input  logic [lsu_pkg::XLEN-1:0]  alu_result,
    input  logic [lsu_pkg::XLEN-1:0]  store_data,
    input  logic [2:0]                funct3,
    input  logic                      mem_ren,
    input  logic                      mem_wen,
    input  logic [4:0]                rd,
    input  logic                      reg_wen,

    output logic                      out_valid,
    input  logic                      out_ready,
    output logic [lsu_pkg::XLEN-1:0]  out_pc,
    output logic [lsu_pkg::XLEN-1:0]  out_inst,
    output logic [4:0]                out_rd,
    output logic                      out_reg_wen,
    output logic [lsu_pkg::XLEN-1:0]  out_result,
    output logic                      mem_req
);

    axi_if axi_bus ();

    lsu lsu_inst (
        .clock       (clock),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .pc          (pc),
        .inst        (inst),
        .alu_result  (alu_result),
        .store_data  (store_data),
        .funct3      (funct3),
        .mem_ren     (mem_ren),
        .mem_wen     (mem_wen),
        .rd          (rd),
        .reg_wen     (reg_wen),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_pc      (out_pc),
        .out_inst    (out_inst),
        .out_rd      (out_rd),
        .out_reg_wen (out_reg_wen),
        .out_result  (out_result),
        .mem_req     (mem_req),
        .bus         (axi_bus.master)
    );

    axi_sram sram_inst (
        .clock (clock),
        .reset (reset),
        .bus   (axi_bus.slave)
    );

endmodule

// File: dv/mem_stage_tb.sv
// testbench for the memory-access stage top level
// stimulus table applied in order, shadow memory for expected results,
// random output back-pressure, hold and order checks, watchdog

`timescale 1ns/1ps

module mem_stage_tb;
    import lsu_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_ENTRIES = 33;
    localparam int OUT_W       = 102;   // pc, inst, rd, reg_wen, result

    localparam logic [1:0] KIND_ALU   = 2'd0;
    localparam logic [1:0] KIND_LOAD  = 2'd1;
    localparam logic [1:0] KIND_STORE = 2'd2;

    typedef struct packed {
        logic [1:0]  kind;
        logic [2:0]  funct3;
        logic [31:0] addr;   // also the ALU result
        logic [31:0] data;
        logic [4:0]  rd;
    } entry_t;

    localparam entry_t STIMULUS [NUM_ENTRIES] = '{
        '{KIND_STORE, FUNCT3_SW,  32'h0000_0000, 32'h1122_3344, 5'd0},
        '{KIND_STORE, FUNCT3_SW,  32'h0000_03fc, 32'hcafe_f00d, 5'd0},
        '{KIND_ALU,   3'b000,     32'h1234_abcd, 32'h0000_0000, 5'd5},
        '{KIND_LOAD,  FUNCT3_LW,  32'h0000_0000, 32'h0000_0000, 5'd1},
        '{KIND_LOAD,  FUNCT3_LW,  32'h0000_03fc, 32'h0000_0000, 5'd2},
        '{KIND_LOAD,  FUNCT3_LW,  32'h0000_0010, 32'h0000_0000, 5'd3},   // never written
        '{KIND_STORE, FUNCT3_SW,  32'h0000_0020, 32'hf0e1_d2c3, 5'd0},
        '{KIND_LOAD,  FUNCT3_LB,  32'h0000_0020, 32'h0000_0000, 5'd4},
        '{KIND_LOAD,  FUNCT3_LB,  32'h0000_0021, 32'h0000_0000, 5'd6},
        '{KIND_LOAD,  FUNCT3_LB,  32'h0000_0022, 32'h0000_0000, 5'd7},
        '{KIND_LOAD,  FUNCT3_LB,  32'h0000_0023, 32'h0000_0000, 5'd8},
        '{KIND_LOAD,  FUNCT3_LBU, 32'h0000_0020, 32'h0000_0000, 5'd9},
        '{KIND_LOAD,  FUNCT3_LBU, 32'h0000_0021, 32'h0000_0000, 5'd10},
        '{KIND_LOAD,  FUNCT3_LBU, 32'h0000_0022, 32'h0000_0000, 5'd11},
        '{KIND_LOAD,  FUNCT3_LBU, 32'h0000_0023, 32'h0000_0000, 5'd12},
        '{KIND_LOAD,  FUNCT3_LH,  32'h0000_0020, 32'h0000_0000, 5'd13},
        '{KIND_LOAD,  FUNCT3_LH,  32'h0000_0022, 32'h0000_0000, 5'd14},
        '{KIND_LOAD,  FUNCT3_LHU, 32'h0000_0020, 32'h0000_0000, 5'd15},
        '{KIND_LOAD,  FUNCT3_LHU, 32'h0000_0022, 32'h0000_0000, 5'd16},
        '{KIND_STORE, FUNCT3_SW,  32'h0000_0040, 32'h0123_4567, 5'd0},
        '{KIND_STORE, FUNCT3_SB,  32'h0000_0040, 32'hdead_bea5, 5'd0},
        '{KIND_LOAD,  FUNCT3_LW,  32'h0000_0040, 32'h0000_0000, 5'd20},
        '{KIND_STORE, FUNCT3_SB,  32'h0000_0041, 32'hdead_be96, 5'd0},
        '{KIND_LOAD,  FUNCT3_LW,  32'h0000_0040, 32'h0000_0000, 5'd21},
        '{KIND_STORE, FUNCT3_SB,  32'h0000_0042, 32'hdead_be87, 5'd0},
        '{KIND_LOAD,  FUNCT3_LW,  32'h0000_0040, 32'h0000_0000, 5'd22},
        '{KIND_STORE, FUNCT3_SB,  32'h0000_0043, 32'hdead_bef8, 5'd0},
        '{KIND_LOAD,  FUNCT3_LW,  32'h0000_0040, 32'h0000_0000, 5'd17},
        '{KIND_STORE, FUNCT3_SH,  32'h0000_0042, 32'haaaa_8001, 5'd0},
        '{KIND_LOAD,  FUNCT3_LW,  32'h0000_0040, 32'h0000_0000, 5'd18},
        '{KIND_STORE, FUNCT3_SH,  32'h0000_0040, 32'h1111_7ffe, 5'd0},
        '{KIND_LOAD,  FUNCT3_LW,  32'h0000_0040, 32'h0000_0000, 5'd19},
        '{KIND_ALU,   3'b000,     32'hffff_fff0, 32'h0000_0000, 5'd31}
    };

    logic              clock, reset;
    logic              in_valid, in_ready, mem_ren, mem_wen, reg_wen;
    logic [XLEN-1:0]   pc, inst, alu_result, store_data;
    logic [2:0]        funct3;
    logic [4:0]        rd;
    logic              out_valid, out_ready, out_reg_wen, mem_req;
    logic [XLEN-1:0]   out_pc, out_inst, out_result;
    logic [4:0]        out_rd;
    logic [OUT_W-1:0]  out_bundle, held_bundle;

    logic [31:0]       shadow [MEM_WORDS];
    logic [31:0]       exp_result [NUM_ENTRIES];
    integer            seed;
    int                out_count;
    bit                held, mem_seen;

    assign out_bundle = {out_pc, out_inst, out_rd, out_reg_wen, out_result};

    mem_stage mem_stage_inst (.*);

    task automatic compare_value(input logic [OUT_W-1:0] got, input logic [OUT_W-1:0] expected,
                                 input string what);
        if (got !== expected) begin
            $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] entry_pc(input int i);
        return 32'h0000_0100 + 32'(4 * i);
    endfunction

    function automatic logic [31:0] entry_inst(input int i);
        return 32'ha500_0000 + 32'(i);
    endfunction

    // RISC-V load width and extension rule
    function automatic logic [31:0] extend_load(input logic [31:0] w, input logic [1:0] off,
                                                input logic [2:0] f3);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(w >> {off, 3'b000});
        h = 16'(w >> {off[1], 4'b0000});
        case (f3)
            FUNCT3_LB:  return {{24{b[7]}}, b};
            FUNCT3_LBU: return {24'h0, b};
            FUNCT3_LH:  return {{16{h[15]}}, h};
            FUNCT3_LHU: return {16'h0, h};
            FUNCT3_LW:  return w;
            default:    return 32'h0;
        endcase
    endfunction

    function automatic logic [OUT_W-1:0] expected_output(input int i);
        return {entry_pc(i), entry_inst(i), STIMULUS[i].rd,
                STIMULUS[i].kind != KIND_STORE, exp_result[i]};
    endfunction

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // walk the table once through the shadow memory
    initial begin
        entry_t                 e;
        logic [MEM_INDEX_W-1:0] idx;
        logic [31:0]            mask, shifted;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = 32'h0;
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            e = STIMULUS[i];
            idx = e.addr[MEM_INDEX_W+1:2];
            exp_result[i] = e.addr;
            if (e.kind == KIND_LOAD) begin
                exp_result[i] = extend_load(shadow[idx], e.addr[1:0], e.funct3);
            end else if (e.kind == KIND_STORE) begin
                case (e.funct3)
                    FUNCT3_SB: mask = 32'h0000_00ff << {e.addr[1:0], 3'b000};
                    FUNCT3_SH: mask = 32'h0000_ffff << {e.addr[1], 4'b0000};
                    default:   mask = 32'hffff_ffff;
                endcase
                shifted = (e.funct3 == FUNCT3_SW) ? e.data
                        : (e.funct3 == FUNCT3_SH) ? e.data << {e.addr[1], 4'b0000}
                        : e.data << {e.addr[1:0], 3'b000};
                shadow[idx] = (shadow[idx] & ~mask) | (shifted & mask);
            end
        end
    end

    initial begin
        entry_t e;
        seed       = 32'hb9a9;
        reset      = 1'b1;
        in_valid   = 1'b0;
        pc         = '0;
        inst       = '0;
        alu_result = '0;
        store_data = '0;
        funct3     = '0;
        mem_ren    = 1'b0;
        mem_wen    = 1'b0;
        rd         = '0;
        reg_wen    = 1'b0;
        out_ready  = 1'b0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        compare_value(OUT_W'(out_valid), OUT_W'(0), "out_valid after reset");
        compare_value(OUT_W'(mem_req), OUT_W'(0), "mem_req after reset");
        compare_value(OUT_W'(in_ready), OUT_W'(1), "in_ready after reset");
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            e = STIMULUS[i];
            in_valid   <= 1'b1;
            pc         <= entry_pc(i);
            inst       <= entry_inst(i);
            alu_result <= e.addr;
            store_data <= e.data;
            funct3     <= e.funct3;
            mem_ren    <= e.kind == KIND_LOAD;
            mem_wen    <= e.kind == KIND_STORE;
            rd         <= e.rd;
            reg_wen    <= e.kind != KIND_STORE;
            @(posedge clock);
            while (!in_ready) @(posedge clock);   // accepted on this edge
        end
        in_valid <= 1'b0;
        wait (out_count == NUM_ENTRIES);
        repeat (4) @(posedge clock);
        $display("** PASS **");
        $finish;
    end

    always @(posedge clock) begin
        if (!reset) begin
            if (mem_req) mem_seen = 1'b1;
            if (held) begin
                compare_value(OUT_W'(out_valid), OUT_W'(1), "out_valid dropped while held");
                compare_value(out_bundle, held_bundle, "output changed while held");
            end
            if (out_valid && !out_ready) begin
                compare_value(OUT_W'(in_ready), OUT_W'(0), "in_ready high while result held");
            end
            held = out_valid && !out_ready;
            held_bundle = out_bundle;
            if (out_valid && out_ready) begin
                compare_value(OUT_W'(out_count < NUM_ENTRIES), OUT_W'(1), "extra output");
                compare_value(out_bundle, expected_output(out_count),
                              $sformatf("output of entry %0d", out_count));
                compare_value(OUT_W'(mem_seen), OUT_W'(STIMULUS[out_count].kind != KIND_ALU),
                              $sformatf("mem_req activity of entry %0d", out_count));
                mem_seen = 1'b0;
                out_count++;
            end
            out_ready <= ($random(seed) & 3) != 0;   // low about one cycle in four
        end
    end

    initial begin
        #(CLK_PERIOD * (20 * NUM_ENTRIES + 40));
        $display("Timeout at %0t ns: the stage hung, only %0d of %0d outputs seen",
                 $time, out_count, NUM_ENTRIES);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: project.f
design/lsu_pkg.sv
design/axi_if.sv
design/load_extract.sv
design/lsu.sv
design/axi_sram.sv
design/mem_stage.sv
dv/mem_stage_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the memory-access stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module mem_stage_tb \
        -f project.f -Mdir obj_dir > build.log 2>&1; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/Vmem_stage_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
echo "simulation passed"
exit 0
